//--- dcache_pkg.sv
/* Data cache shared definitions */

package dcache_pkg;

    // ==================================================
    // Geometry
    // ==================================================
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    // Two ways are hard wired in the LRU and hit logic
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 8;
    localparam int WORDS_PER_LINE = 4;

    // ==================================================
    // Address fields
    // ==================================================
    // Address layout is tag | set | word | byte
    localparam int BYTE_OFF_W = 2;
    localparam int WORD_OFF_W = 2;
    localparam int SET_W      = 3;
    localparam int TAG_W      = ADDR_W - SET_W - WORD_OFF_W - BYTE_OFF_W;

    // Request sequencing in the controller
    typedef enum logic [2:0] {
        IDLE,
        WRITE_BACK,
        FILL,
        WRITE_MERGE,
        READ_OK
    } ctrl_state_e;

    // AXI burst master states
    typedef enum logic [2:0] {
        B_IDLE,
        B_AW,
        B_W,
        B_B,
        B_AR,
        B_R
    } burst_state_e;

endpackage

//--- dcache_tag_store.sv
/* Cache tag and LRU store */

`timescale 1ns/1ps

module dcache_tag_store (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [dcache_pkg::SET_W-1:0]   lookup_set,
    input  logic [dcache_pkg::TAG_W-1:0]   lookup_tag,
    input  logic                           touch,
    input  logic                           touch_way,
    input  logic                           meta_write,
    input  logic                           meta_way,
    input  logic [dcache_pkg::SET_W-1:0]   meta_set,
    input  logic [dcache_pkg::TAG_W-1:0]   meta_tag,
    input  logic                           meta_dirty,
    input  logic                           cpu_we,
    input  logic                           cpu_way,
    input  logic [dcache_pkg::SET_W-1:0]   cpu_set,
    output logic                           hit,
    output logic                           hit_way,
    output logic                           victim_way,
    output logic                           victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0]   victim_tag
);

    logic [dcache_pkg::TAG_W-1:0] tags  [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    logic                         valid [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    logic                         dirty [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];
    logic                         lru   [dcache_pkg::NUM_SETS];
    logic                         match0;
    logic                         match1;

    // Compare both ways of the set
    assign match0 = valid[0][lookup_set] && (tags[0][lookup_set] == lookup_tag);
    assign match1 = valid[1][lookup_set] && (tags[1][lookup_set] == lookup_tag);
    assign hit     = match0 || match1;
    assign hit_way = match1;

    // LRU bit names the way to replace
    assign victim_way   = lru[lookup_set];
    assign victim_dirty = valid[victim_way][lookup_set] && dirty[victim_way][lookup_set];
    assign victim_tag   = tags[victim_way][lookup_set];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
                lru[s] <= 1'b0;
                for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                    valid[w][s] <= 1'b0;
                    dirty[w][s] <= 1'b0;
                end
            end
        end else begin
            if (touch) begin
                lru[lookup_set] <= ~touch_way;
            end
            if (meta_write) begin
                valid[meta_way][meta_set] <= 1'b1;
                dirty[meta_way][meta_set] <= meta_dirty;
            end
            if (cpu_we) begin
                dirty[cpu_way][cpu_set] <= 1'b1;
            end
        end
    end

    // Tag array written on a line fill
    always_ff @(posedge clk) begin
        if (meta_write) begin
            tags[meta_way][meta_set] <= meta_tag;
        end
    end

endmodule

//--- dcache_data_store.sv
/* Cache line data array */

`timescale 1ns/1ps

module dcache_data_store (
    input  logic                                clk,
    input  logic                                cpu_we,
    input  logic                                cpu_way,
    input  logic [dcache_pkg::SET_W-1:0]        cpu_set,
    input  logic [dcache_pkg::WORD_OFF_W-1:0]   cpu_word,
    input  logic [dcache_pkg::DATA_W-1:0]       cpu_wdata,
    input  logic [dcache_pkg::DATA_W/8-1:0]     cpu_be,
    input  logic                                fill_we,
    input  logic                                fill_way,
    input  logic [dcache_pkg::SET_W-1:0]        fill_set,
    input  logic [dcache_pkg::WORD_OFF_W-1:0]   fill_word,
    input  logic [dcache_pkg::DATA_W-1:0]       fill_data,
    input  logic                                rd_way_a,
    input  logic [dcache_pkg::SET_W-1:0]        rd_set_a,
    input  logic [dcache_pkg::WORD_OFF_W-1:0]   rd_word_a,
    input  logic                                rd_way_b,
    input  logic [dcache_pkg::SET_W-1:0]        rd_set_b,
    input  logic [dcache_pkg::WORD_OFF_W-1:0]   rd_word_b,
    output logic [dcache_pkg::DATA_W-1:0]       rdata_a,
    output logic [dcache_pkg::DATA_W-1:0]       rdata_b
);

    logic [dcache_pkg::DATA_W-1:0] mem [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS]
                                       [dcache_pkg::WORDS_PER_LINE];
    logic [dcache_pkg::DATA_W-1:0] be_mask;
    logic [dcache_pkg::DATA_W-1:0] old_word;

    // Expand byte enables to a bit mask
    always_comb begin
        for (int i = 0; i < dcache_pkg::DATA_W / 8; i++) begin
            be_mask[i*8 +: 8] = {8{cpu_be[i]}};
        end
    end

    assign old_word = mem[cpu_way][cpu_set][cpu_word];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_way][cpu_set][cpu_word] <= (old_word & ~be_mask) | (cpu_wdata & be_mask);
        end
        // Fill beats replace whole words
        if (fill_we) begin
            mem[fill_way][fill_set][fill_word] <= fill_data;
        end
    end

    // Port A serves the CPU, port B the write-back burst
    assign rdata_a = mem[rd_way_a][rd_set_a][rd_word_a];
    assign rdata_b = mem[rd_way_b][rd_set_b][rd_word_b];

endmodule

//--- dcache_burst_engine.sv
/* AXI line burst master */

`timescale 1ns/1ps

module dcache_burst_engine (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wb_start,
    input  logic                                fill_start,
    input  logic [dcache_pkg::ADDR_W-1:0]       line_addr,
    input  logic                                line_way,
    input  logic [dcache_pkg::SET_W-1:0]        line_set,
    input  logic [dcache_pkg::DATA_W-1:0]       rdata_b,
    input  logic                                awready,
    input  logic                                wready,
    input  logic                                bvalid,
    input  logic                                arready,
    input  logic                                rvalid,
    input  logic [dcache_pkg::DATA_W-1:0]       rdata,
    input  logic                                rlast,
    output logic                                done,
    output logic                                fill_we,
    output logic                                fill_way,
    output logic [dcache_pkg::SET_W-1:0]        fill_set,
    output logic [dcache_pkg::WORD_OFF_W-1:0]   fill_word,
    output logic [dcache_pkg::DATA_W-1:0]       fill_data,
    output logic                                rd_way_b,
    output logic [dcache_pkg::SET_W-1:0]        rd_set_b,
    output logic [dcache_pkg::WORD_OFF_W-1:0]   rd_word_b,
    output logic                                awvalid,
    output logic [dcache_pkg::ADDR_W-1:0]       awaddr,
    output logic                                wvalid,
    output logic [dcache_pkg::DATA_W-1:0]       wdata,
    output logic                                wlast,
    output logic                                bready,
    output logic                                arvalid,
    output logic [dcache_pkg::ADDR_W-1:0]       araddr,
    output logic                                rready
);

    dcache_pkg::burst_state_e               state;
    logic [dcache_pkg::WORD_OFF_W-1:0]      ptr;
    logic [dcache_pkg::ADDR_W-1:0]          addr_q;
    logic                                   way_q;
    logic [dcache_pkg::SET_W-1:0]           set_q;
    logic                                   last_word;

    assign last_word = (ptr == dcache_pkg::WORD_OFF_W'(dcache_pkg::WORDS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= dcache_pkg::B_IDLE;
            ptr   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                dcache_pkg::B_IDLE: begin
                    ptr <= '0;
                    if (wb_start) begin
                        state <= dcache_pkg::B_AW;
                    end else if (fill_start) begin
                        state <= dcache_pkg::B_AR;
                    end
                end
                dcache_pkg::B_AW: if (awready) state <= dcache_pkg::B_W;
                dcache_pkg::B_W: begin
                    if (wready) begin
                        ptr <= ptr + 1'b1;
                        if (last_word) state <= dcache_pkg::B_B;
                    end
                end
                dcache_pkg::B_B: begin
                    if (bvalid) begin
                        state <= dcache_pkg::B_IDLE;
                        done  <= 1'b1;
                    end
                end
                dcache_pkg::B_AR: if (arready) state <= dcache_pkg::B_R;
                dcache_pkg::B_R: begin
                    if (rvalid) begin
                        ptr <= ptr + 1'b1;
                        if (rlast) begin
                            state <= dcache_pkg::B_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= dcache_pkg::B_IDLE;
            endcase
        end
    end

    // Line address and location held for the whole burst
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::B_IDLE && (wb_start || fill_start)) begin
            addr_q <= line_addr;
            way_q  <= line_way;
            set_q  <= line_set;
        end
    end

    // ==================================================
    // AXI channel outputs
    // ==================================================
    assign awvalid = (state == dcache_pkg::B_AW);
    assign awaddr  = addr_q;
    assign wvalid  = (state == dcache_pkg::B_W);
    assign wdata   = rdata_b;
    assign wlast   = wvalid && last_word;
    assign bready  = (state == dcache_pkg::B_B);
    assign arvalid = (state == dcache_pkg::B_AR);
    assign araddr  = addr_q;
    assign rready  = (state == dcache_pkg::B_R);

    // Fill writes and write-back reads share the word pointer
    assign fill_we   = rready && rvalid;
    assign fill_way  = way_q;
    assign fill_set  = set_q;
    assign fill_word = ptr;
    assign fill_data = rdata;
    assign rd_way_b  = way_q;
    assign rd_set_b  = set_q;
    assign rd_word_b = ptr;

endmodule

//--- dcache_ctrl.sv
/* Cache request controller */

`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [dcache_pkg::ADDR_W-1:0]       address,
    input  logic [dcache_pkg::DATA_W-1:0]       write_data,
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [dcache_pkg::DATA_W/8-1:0]     byte_enable,
    input  logic                                read_ack,
    input  logic                                hit,
    input  logic                                hit_way,
    input  logic                                victim_way,
    input  logic                                victim_dirty,
    input  logic [dcache_pkg::TAG_W-1:0]        victim_tag,
    input  logic                                done,
    input  logic [dcache_pkg::DATA_W-1:0]       rdata_a,
    output logic                                req_ready,
    output logic                                read_valid,
    output logic [dcache_pkg::DATA_W-1:0]       read_data,
    output logic [dcache_pkg::SET_W-1:0]        lookup_set,
    output logic [dcache_pkg::TAG_W-1:0]        lookup_tag,
    output logic                                touch,
    output logic                                touch_way,
    output logic                                meta_write,
    output logic                                meta_way,
    output logic [dcache_pkg::SET_W-1:0]        meta_set,
    output logic [dcache_pkg::TAG_W-1:0]        meta_tag,
    output logic                                meta_dirty,
    output logic                                cpu_we,
    output logic                                cpu_way,
    output logic [dcache_pkg::SET_W-1:0]        cpu_set,
    output logic [dcache_pkg::WORD_OFF_W-1:0]   cpu_word,
    output logic [dcache_pkg::DATA_W-1:0]       cpu_wdata,
    output logic [dcache_pkg::DATA_W/8-1:0]     cpu_be,
    output logic                                rd_way_a,
    output logic [dcache_pkg::SET_W-1:0]        rd_set_a,
    output logic [dcache_pkg::WORD_OFF_W-1:0]   rd_word_a,
    output logic                                wb_start,
    output logic                                fill_start,
    output logic [dcache_pkg::ADDR_W-1:0]       line_addr,
    output logic                                line_way,
    output logic [dcache_pkg::SET_W-1:0]        line_set
);

    localparam int LOW_W = dcache_pkg::WORD_OFF_W + dcache_pkg::BYTE_OFF_W;

    dcache_pkg::ctrl_state_e                state;
    logic                                   idle;
    logic                                   accept;
    logic                                   miss;
    logic                                   fill_done;
    logic [dcache_pkg::TAG_W-1:0]           a_tag;
    logic [dcache_pkg::SET_W-1:0]           a_set;
    logic [dcache_pkg::WORD_OFF_W-1:0]      a_word;

    // Held request
    logic                                   pend_write;
    logic                                   pend_way;
    logic [dcache_pkg::TAG_W-1:0]           pend_tag;
    logic [dcache_pkg::SET_W-1:0]           pend_set;
    logic [dcache_pkg::WORD_OFF_W-1:0]      pend_word;
    logic [dcache_pkg::DATA_W-1:0]          pend_data;
    logic [dcache_pkg::DATA_W/8-1:0]        pend_be;

    assign a_tag  = address[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign a_set  = address[LOW_W +: dcache_pkg::SET_W];
    assign a_word = address[dcache_pkg::BYTE_OFF_W +: dcache_pkg::WORD_OFF_W];

    assign idle      = (state == dcache_pkg::IDLE);
    assign req_ready = idle;
    assign accept    = req_valid && req_ready;
    assign miss      = accept && !hit;
    assign fill_done = (state == dcache_pkg::FILL) && done;

    // ==================================================
    // Tag store and data store ports
    // ==================================================
    // Live address while idle, held request otherwise
    assign lookup_set = idle ? a_set : pend_set;
    assign lookup_tag = idle ? a_tag : pend_tag;
    assign touch      = (accept && hit) || fill_done;
    assign touch_way  = idle ? hit_way : pend_way;

    assign meta_write = fill_done;
    assign meta_way   = pend_way;
    assign meta_set   = pend_set;
    assign meta_tag   = pend_tag;
    assign meta_dirty = pend_write;

    // Write hits land in IDLE, write misses merge after the fill
    assign cpu_we    = (accept && hit && req_write) || (state == dcache_pkg::WRITE_MERGE);
    assign cpu_way   = idle ? hit_way : pend_way;
    assign cpu_set   = idle ? a_set : pend_set;
    assign cpu_word  = idle ? a_word : pend_word;
    assign cpu_wdata = idle ? write_data : pend_data;
    assign cpu_be    = idle ? byte_enable : pend_be;

    assign rd_way_a   = pend_way;
    assign rd_set_a   = pend_set;
    assign rd_word_a  = pend_word;
    assign read_data  = rdata_a;
    assign read_valid = (state == dcache_pkg::READ_OK);

    // Burst requests send a dirty victim line before the fill
    assign wb_start   = miss && victim_dirty;
    assign fill_start = (miss && !victim_dirty) || ((state == dcache_pkg::WRITE_BACK) && done);
    assign line_addr  = idle ? {(victim_dirty ? victim_tag : a_tag), a_set, LOW_W'(0)}
                             : {pend_tag, pend_set, LOW_W'(0)};
    assign line_way   = idle ? victim_way : pend_way;
    assign line_set   = idle ? a_set : pend_set;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= dcache_pkg::IDLE;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (accept && hit && !req_write) begin
                        state <= dcache_pkg::READ_OK;
                    end else if (miss) begin
                        state <= victim_dirty ? dcache_pkg::WRITE_BACK : dcache_pkg::FILL;
                    end
                end
                dcache_pkg::WRITE_BACK: if (done) state <= dcache_pkg::FILL;
                dcache_pkg::FILL: begin
                    if (done) begin
                        state <= pend_write ? dcache_pkg::WRITE_MERGE : dcache_pkg::READ_OK;
                    end
                end
                dcache_pkg::WRITE_MERGE: state <= dcache_pkg::IDLE;
                dcache_pkg::READ_OK: if (read_ack) state <= dcache_pkg::IDLE;
                default: state <= dcache_pkg::IDLE;
            endcase
        end
    end

    // Every accepted request is captured
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_write <= req_write;
            pend_way   <= hit ? hit_way : victim_way;
            pend_tag   <= a_tag;
            pend_set   <= a_set;
            pend_word  <= a_word;
            pend_data  <= write_data;
            pend_be    <= byte_enable;
        end
    end

endmodule

//--- dcache_top.sv
/* Data cache top level */

`timescale 1ns/1ps

module dcache_top (
    input  logic                                clk,
    input  logic                                rst_n,
    // CPU side
    input  logic [dcache_pkg::ADDR_W-1:0]       address,
    input  logic [dcache_pkg::DATA_W-1:0]       write_data,
    input  logic                                req_valid,
    output logic                                req_ready,
    input  logic                                req_write,
    input  logic [dcache_pkg::DATA_W/8-1:0]     byte_enable,
    output logic [dcache_pkg::DATA_W-1:0]       read_data,
    output logic                                read_valid,
    input  logic                                read_ack,
    // AXI side
    output logic                                awvalid,
    input  logic                                awready,
    output logic [dcache_pkg::ADDR_W-1:0]       awaddr,
    output logic                                wvalid,
    input  logic                                wready,
    output logic [dcache_pkg::DATA_W-1:0]       wdata,
    output logic                                wlast,
    input  logic                                bvalid,
    output logic                                bready,
    output logic                                arvalid,
    input  logic                                arready,
    output logic [dcache_pkg::ADDR_W-1:0]       araddr,
    input  logic                                rvalid,
    output logic                                rready,
    input  logic [dcache_pkg::DATA_W-1:0]       rdata,
    input  logic                                rlast
);

    logic                                   hit, hit_way, victim_way, victim_dirty;
    logic [dcache_pkg::TAG_W-1:0]           victim_tag, lookup_tag, meta_tag;
    logic [dcache_pkg::SET_W-1:0]           lookup_set, meta_set, cpu_set, line_set;
    logic [dcache_pkg::SET_W-1:0]           rd_set_a, rd_set_b, fill_set;
    logic                                   touch, touch_way, meta_write, meta_way, meta_dirty;
    logic                                   cpu_we, cpu_way, rd_way_a, rd_way_b;
    logic                                   fill_we, fill_way, line_way;
    logic [dcache_pkg::WORD_OFF_W-1:0]      cpu_word, rd_word_a, rd_word_b, fill_word;
    logic [dcache_pkg::DATA_W-1:0]          cpu_wdata, rdata_a, rdata_b, fill_data;
    logic [dcache_pkg::DATA_W/8-1:0]        cpu_be;
    logic                                   wb_start, fill_start, done;
    logic [dcache_pkg::ADDR_W-1:0]          line_addr;

    dcache_ctrl dcache_ctrl_inst (
        .clk, .rst_n, .address, .write_data, .req_valid, .req_write, .byte_enable,
        .read_ack, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .done,
        .rdata_a, .req_ready, .read_valid, .read_data, .lookup_set, .lookup_tag,
        .touch, .touch_way, .meta_write, .meta_way, .meta_set, .meta_tag, .meta_dirty,
        .cpu_we, .cpu_way, .cpu_set, .cpu_word, .cpu_wdata, .cpu_be,
        .rd_way_a, .rd_set_a, .rd_word_a, .wb_start, .fill_start,
        .line_addr, .line_way, .line_set
    );

    dcache_tag_store dcache_tag_store_inst (
        .clk, .rst_n, .lookup_set, .lookup_tag, .touch, .touch_way,
        .meta_write, .meta_way, .meta_set, .meta_tag, .meta_dirty,
        .cpu_we, .cpu_way, .cpu_set,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    dcache_data_store dcache_data_store_inst (
        .clk, .cpu_we, .cpu_way, .cpu_set, .cpu_word, .cpu_wdata, .cpu_be,
        .fill_we, .fill_way, .fill_set, .fill_word, .fill_data,
        .rd_way_a, .rd_set_a, .rd_word_a, .rd_way_b, .rd_set_b, .rd_word_b,
        .rdata_a, .rdata_b
    );

    dcache_burst_engine dcache_burst_engine_inst (
        .clk, .rst_n, .wb_start, .fill_start, .line_addr, .line_way, .line_set,
        .rdata_b, .awready, .wready, .bvalid, .arready, .rvalid, .rdata, .rlast,
        .done, .fill_we, .fill_way, .fill_set, .fill_word, .fill_data,
        .rd_way_b, .rd_set_b, .rd_word_b, .awvalid, .awaddr, .wvalid, .wdata,
        .wlast, .bready, .arvalid, .araddr, .rready
    );

endmodule

//--- tb_dcache.sv
/* Data cache testbench */

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

module tb_dcache;

    localparam int          NUM_ENTRIES = 20;
    localparam int          MEM_WORDS   = 4096;
    localparam int unsigned SEED        = 32'h6ee4_b0eb;
    localparam logic [31:0] PATTERN     = 32'h5a5a_0000;
    localparam int          WPL         = dcache_pkg::WORDS_PER_LINE;

    logic        clk;
    logic        rst_n;
    logic [31:0] address;
    logic [31:0] write_data;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [3:0]  byte_enable;
    logic [31:0] read_data;
    logic        read_valid;
    logic        read_ack;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        wlast;
    logic        bvalid;
    logic        bready;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic        rlast;

    // Stimulus table with expected read value and AXI traffic per entry
    logic        tbl_write [NUM_ENTRIES];
    logic [31:0] tbl_addr  [NUM_ENTRIES];
    logic [31:0] tbl_data  [NUM_ENTRIES];
    logic [3:0]  tbl_be    [NUM_ENTRIES];
    logic [31:0] tbl_exp   [NUM_ENTRIES];
    int          tbl_ar    [NUM_ENTRIES];
    int          tbl_aw    [NUM_ENTRIES];
    int          tbl_len;

    logic [31:0] ref_words [MEM_WORDS];
    logic [31:0] mem_words [MEM_WORDS];

    int errors;
    int checks;
    int cur_entry;
    int ar_count;
    int aw_count;
    int w_count;

    tb_clock_gen tb_clock_gen_inst (.clk);

    dcache_top dcache_top_inst (.*);

    function automatic int word_index(input logic [31:0] byte_addr);
        return int'(byte_addr >> 2) % MEM_WORDS;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s in entry %0d: got 0x%h, expected 0x%h",
                     name, cur_entry, got, exp);
        end
    endtask

    // Expected reads follow the reference word model as the table is built
    task automatic add_entry(input logic write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] be,
                             input int ar, input int aw);
        int idx;
        idx = word_index(addr);
        tbl_write[tbl_len] = write;
        tbl_addr[tbl_len]  = addr;
        tbl_data[tbl_len]  = data;
        tbl_be[tbl_len]    = be;
        tbl_ar[tbl_len]    = ar;
        tbl_aw[tbl_len]    = aw;
        if (write) begin
            ref_words[idx]   = merge_bytes(ref_words[idx], data, be);
            tbl_exp[tbl_len] = '0;
        end else begin
            tbl_exp[tbl_len] = ref_words[idx];
        end
        tbl_len++;
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================
    task automatic build_table();
        // Fill, hit and partial write hit in set 1
        add_entry(1'b0, 32'h0000_0010, 32'h0, 4'h0, 1, 0);
        add_entry(1'b0, 32'h0000_0018, 32'h0, 4'h0, 0, 0);
        add_entry(1'b1, 32'h0000_0014, 32'hdead_beef, 4'b0101, 0, 0);
        add_entry(1'b0, 32'h0000_0014, 32'h0, 4'h0, 0, 0);
        // Partial write miss in set 2
        add_entry(1'b1, 32'h0000_00a4, 32'h1234_5678, 4'b1100, 1, 0);
        add_entry(1'b0, 32'h0000_00a4, 32'h0, 4'h0, 0, 0);
        // Third tag in set 1 evicts the dirty line before it is read back
        add_entry(1'b0, 32'h0000_0110, 32'h0, 4'h0, 1, 0);
        add_entry(1'b0, 32'h0000_0190, 32'h0, 4'h0, 1, 1);
        add_entry(1'b0, 32'h0000_0014, 32'h0, 4'h0, 1, 0);
        // Order A B A C in set 5 keeps A and drops B
        add_entry(1'b0, 32'h0000_1050, 32'h0, 4'h0, 1, 0);
        add_entry(1'b0, 32'h0000_2050, 32'h0, 4'h0, 1, 0);
        add_entry(1'b0, 32'h0000_1050, 32'h0, 4'h0, 0, 0);
        add_entry(1'b0, 32'h0000_3050, 32'h0, 4'h0, 1, 0);
        add_entry(1'b0, 32'h0000_1050, 32'h0, 4'h0, 0, 0);
        add_entry(1'b0, 32'h0000_2050, 32'h0, 4'h0, 1, 0);
        // Write misses over dirty victims in set 2
        add_entry(1'b1, 32'h0000_0124, 32'hcafe_f00d, 4'b1111, 1, 0);
        add_entry(1'b1, 32'h0000_01a8, 32'h0bad_c0de, 4'b0011, 1, 1);
        add_entry(1'b0, 32'h0000_00a4, 32'h0, 4'h0, 1, 1);
        add_entry(1'b0, 32'h0000_0124, 32'h0, 4'h0, 1, 1);
        add_entry(1'b0, 32'h0000_01a8, 32'h0, 4'h0, 1, 0);
    endtask

    task automatic apply_entry(input int i);
        int ar_start;
        int aw_start;
        int w_start;
        cur_entry   = i;
        ar_start    = ar_count;
        aw_start    = aw_count;
        w_start     = w_count;
        address     = tbl_addr[i];
        write_data  = tbl_data[i];
        byte_enable = tbl_be[i];
        req_write   = tbl_write[i];
        req_valid   = 1'b1;
        do @(posedge clk); while (!req_ready);
        #1;
        req_valid = 1'b0;
        if (tbl_write[i]) begin
            // Write is complete once the cache is ready again
            do @(posedge clk); while (!req_ready);
            #1;
        end else begin
            do @(posedge clk); while (!read_valid);
            check_value("read_data", read_data, tbl_exp[i]);
            check_value("req_ready", 32'(req_ready), 32'h0);
            #1;
            read_ack = 1'b1;
            @(posedge clk);
            #1;
            read_ack = 1'b0;
        end
        check_value("ar handshakes", 32'(ar_count - ar_start), 32'(tbl_ar[i]));
        check_value("aw handshakes", 32'(aw_count - aw_start), 32'(tbl_aw[i]));
        check_value("w beats", 32'(w_count - w_start), 32'(tbl_aw[i] * WPL));
    endtask

    // ==================================================
    // AXI memory model
    // ==================================================
    initial begin
        int unsigned seed;
        logic [31:0] wr_addr;
        logic [31:0] rd_addr;
        int          wr_beat;
        int          rd_beat;
        logic        b_busy;
        logic        rd_busy;
        logic        r_fire;
        seed = SEED;
        void'($urandom(seed));
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        rlast    = 1'b0;
        ar_count = 0;
        aw_count = 0;
        w_count  = 0;
        wr_addr  = '0;
        rd_addr  = '0;
        wr_beat  = 0;
        rd_beat  = 0;
        b_busy   = 1'b0;
        rd_busy  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) mem_words[i] = 32'(i * 4) ^ PATTERN;
        forever begin
            @(posedge clk);
            r_fire = rvalid && rready;
            if (!rst_n) begin
                b_busy  = 1'b0;
                rd_busy = 1'b0;
            end else begin
                if (awvalid && awready) begin
                    wr_addr = awaddr;
                    wr_beat = 0;
                    aw_count++;
                end
                if (wvalid && wready) begin
                    check_value("wlast", 32'(wlast), 32'(wr_beat == WPL - 1));
                    mem_words[word_index(wr_addr + 32'(wr_beat * 4))] = wdata;
                    wr_beat++;
                    w_count++;
                    if (wlast) b_busy = 1'b1;
                end
                if (bvalid && bready) b_busy = 1'b0;
                if (arvalid && arready) begin
                    rd_addr = araddr;
                    rd_beat = 0;
                    rd_busy = 1'b1;
                    ar_count++;
                end
                if (r_fire) begin
                    rd_beat++;
                    if (rd_beat == WPL) rd_busy = 1'b0;
                end
            end
            #1;
            awready = ($urandom % 4) != 0;
            wready  = ($urandom % 4) != 0;
            arready = ($urandom % 4) != 0;
            // A raised valid stays up until its handshake
            bvalid  = b_busy && (bvalid || ($urandom % 2) == 0);
            rvalid  = rd_busy && ((rvalid && !r_fire) || ($urandom % 2) == 0);
            rdata   = rd_busy ? mem_words[word_index(rd_addr + 32'(rd_beat * 4))] : '0;
            rlast   = rd_busy && (rd_beat == WPL - 1);
        end
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        errors      = 0;
        checks      = 0;
        cur_entry   = 0;
        tbl_len     = 0;
        rst_n       = 1'b0;
        address     = '0;
        write_data  = '0;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        byte_enable = '0;
        read_ack    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) ref_words[i] = 32'(i * 4) ^ PATTERN;
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        checks++;
        assert (req_ready && !read_valid && !awvalid && !wvalid && !bready
                && !arvalid && !rready) else begin
            errors++;
            $display("Cache outputs are not idle after reset");
        end
        for (int i = 0; i < tbl_len; i++) apply_entry(i);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_ENTRIES * 200) @(posedge clk);
        $display("Timeout after %0d cycles before the table finished", NUM_ENTRIES * 200);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- all.f
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_burst_engine.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - dcache_pkg.sv
      - dcache_tag_store.sv
      - dcache_data_store.sv
      - dcache_burst_engine.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv
